//--- src/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// instruction, pc and immediate width
`define DATA_WIDTH 32

// general purpose register file size
`define GPR_NUM 32

// register address width, follows from the register count
`define REG_ADDR_WIDTH $clog2(`GPR_NUM)

// field positions shared by the formats
`define RD_LSB 0
`define RJ_LSB 5
`define RK_LSB 10

// alu operation and result selector widths
`define ALU_OP_WIDTH 8
`define ALU_SEL_WIDTH 3

`endif

//--- src/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    // operation handed to the execute stage
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_NOP = 8'd0,
        // arithmetic and compare
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        // logic
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // upper immediate
        ALU_LUI,
        ALU_PCADDU,
        // word memory access
        ALU_LD_W,
        ALU_ST_W,
        // jumps and branches
        ALU_JIRL,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    // which execute result the instruction produces
    typedef enum logic [`ALU_SEL_WIDTH-1:0] {
        SEL_NOP = 3'd0,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_MOVE,
        SEL_MEM,
        SEL_JUMP
    } alu_sel_e;

    // 2RI16 major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_JIRL = 6'b010011,
        OP_BEQ  = 6'b010110,
        OP_BNE  = 6'b010111,
        OP_BLT  = 6'b011000,
        OP_BGE  = 6'b011001,
        OP_BLTU = 6'b011010,
        OP_BGEU = 6'b011011
    } op_2ri16_e;

    // 2RI12 opcode, bits 31:22
    typedef enum logic [9:0] {
        OP_SLTI   = 10'b0000001000,
        OP_SLTUI  = 10'b0000001001,
        OP_ADDI_W = 10'b0000001010,
        OP_ANDI   = 10'b0000001101,
        OP_ORI    = 10'b0000001110,
        OP_XORI   = 10'b0000001111,
        OP_LD_W   = 10'b0010100010,
        OP_ST_W   = 10'b0010100110
    } op_2ri12_e;

    // 3R opcode, bits 31:15
    typedef enum logic [16:0] {
        OP_ADD_W = 17'b00000000000100000,
        OP_SUB_W = 17'b00000000000100010,
        OP_SLT   = 17'b00000000000100100,
        OP_SLTU  = 17'b00000000000100101,
        OP_AND   = 17'b00000000000101001,
        OP_OR    = 17'b00000000000101010,
        OP_XOR   = 17'b00000000000101011
    } op_3r_e;

    // 1RI20 opcode, bits 31:25
    typedef enum logic [6:0] {
        OP_LU12I_W   = 7'b0001010,
        OP_PCADDU12I = 7'b0001110
    } op_1ri20_e;

endpackage

//--- src/decoder_2ri16.sv
`include "decode_defs.svh"

// 2RI16 format {opcode[6], offs16, rj, rd}
// conditional branches and jirl, purely combinational
module decoder_2ri16 (
    input  logic [`DATA_WIDTH-1:0]         instr_i,
    output logic                           match_o,
    // {second, first}
    output logic [1:0]                     reg_read_valid_o,
    output logic [2*`REG_ADDR_WIDTH-1:0]   reg_read_addr_o,
    output logic                           use_imm_o,
    output logic [`DATA_WIDTH-1:0]         imm_o,
    output logic                           reg_write_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr_o,
    output decode_pkg::alu_op_e            aluop_o,
    output decode_pkg::alu_sel_e           alusel_o
);
    import decode_pkg::*;

    op_2ri16_e                  opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [15:0]                offs16;

    assign opcode = op_2ri16_e'(instr_i[31:26]);
    assign rd     = instr_i[`RD_LSB +: `REG_ADDR_WIDTH];
    assign rj     = instr_i[`RJ_LSB +: `REG_ADDR_WIDTH];
    assign offs16 = instr_i[25:10];

    always_comb begin
        // common branch decode, both operands compared
        match_o           = 1'b1;
        reg_read_valid_o  = 2'b11;
        reg_read_addr_o   = {rd, rj};
        use_imm_o         = 1'b0;
        // word offset, sign extended and scaled to bytes
        imm_o             = {{(`DATA_WIDTH-18){offs16[15]}}, offs16, 2'b00};
        reg_write_valid_o = 1'b0;
        reg_write_addr_o  = '0;
        aluop_o           = ALU_NOP;
        alusel_o          = SEL_JUMP;
        case (opcode)
            OP_JIRL: begin
                aluop_o           = ALU_JIRL;
                // link register gets the return address
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {{`REG_ADDR_WIDTH{1'b0}}, rj};
            end
            OP_BEQ:  aluop_o = ALU_BEQ;
            OP_BNE:  aluop_o = ALU_BNE;
            OP_BLT:  aluop_o = ALU_BLT;
            OP_BGE:  aluop_o = ALU_BGE;
            OP_BLTU: aluop_o = ALU_BLTU;
            OP_BGEU: aluop_o = ALU_BGEU;
            default: begin
                // not ours, stay silent for the merge
                match_o           = 1'b0;
                reg_read_valid_o  = '0;
                reg_read_addr_o   = '0;
                imm_o             = '0;
                aluop_o           = ALU_NOP;
                alusel_o          = SEL_NOP;
            end
        endcase
    end

endmodule

//--- src/decoder_2ri12.sv
`include "decode_defs.svh"

// 2RI12 format {opcode[10], si12, rj, rd}
// immediate alu ops plus ld.w and st.w
module decoder_2ri12 (
    input  logic [`DATA_WIDTH-1:0]         instr_i,
    output logic                           match_o,
    // {second, first}
    output logic [1:0]                     reg_read_valid_o,
    output logic [2*`REG_ADDR_WIDTH-1:0]   reg_read_addr_o,
    output logic                           use_imm_o,
    output logic [`DATA_WIDTH-1:0]         imm_o,
    output logic                           reg_write_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr_o,
    output decode_pkg::alu_op_e            aluop_o,
    output decode_pkg::alu_sel_e           alusel_o
);
    import decode_pkg::*;

    op_2ri12_e                  opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [11:0]                imm12;
    logic [`DATA_WIDTH-1:0]     imm_sext;
    logic [`DATA_WIDTH-1:0]     imm_zext;

    assign opcode   = op_2ri12_e'(instr_i[31:22]);
    assign rd       = instr_i[`RD_LSB +: `REG_ADDR_WIDTH];
    assign rj       = instr_i[`RJ_LSB +: `REG_ADDR_WIDTH];
    assign imm12    = instr_i[21:10];
    assign imm_sext = {{(`DATA_WIDTH-12){imm12[11]}}, imm12};
    assign imm_zext = {{(`DATA_WIDTH-12){1'b0}}, imm12};

    always_comb begin
        // rj op imm -> rd unless overridden below
        match_o           = 1'b1;
        reg_read_valid_o  = 2'b01;
        reg_read_addr_o   = {{`REG_ADDR_WIDTH{1'b0}}, rj};
        use_imm_o         = 1'b1;
        imm_o             = imm_sext;
        reg_write_valid_o = 1'b1;
        reg_write_addr_o  = rd;
        aluop_o           = ALU_NOP;
        alusel_o          = SEL_ARITH;
        case (opcode)
            OP_SLTI:   aluop_o = ALU_SLT;
            OP_SLTUI:  aluop_o = ALU_SLTU;
            OP_ADDI_W: aluop_o = ALU_ADD;
            // logic immediates are unsigned
            OP_ANDI, OP_ORI, OP_XORI: begin
                imm_o    = imm_zext;
                alusel_o = SEL_LOGIC;
                case (opcode)
                    OP_ANDI: aluop_o = ALU_AND;
                    OP_ORI:  aluop_o = ALU_OR;
                    default: aluop_o = ALU_XOR;
                endcase
            end
            OP_LD_W: begin
                aluop_o  = ALU_LD_W;
                alusel_o = SEL_MEM;
            end
            OP_ST_W: begin
                aluop_o           = ALU_ST_W;
                alusel_o          = SEL_MEM;
                // rd is the store data, nothing written back
                reg_read_valid_o  = 2'b11;
                reg_read_addr_o   = {rd, rj};
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
            end
            default: begin
                match_o           = 1'b0;
                reg_read_valid_o  = '0;
                reg_read_addr_o   = '0;
                use_imm_o         = 1'b0;
                imm_o             = '0;
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
                alusel_o          = SEL_NOP;
            end
        endcase
    end

endmodule

//--- src/decoder_3r.sv
`include "decode_defs.svh"

// 3R format {opcode[17], rk, rj, rd}
// register-register arithmetic and logic
module decoder_3r (
    input  logic [`DATA_WIDTH-1:0]         instr_i,
    output logic                           match_o,
    // {second, first}
    output logic [1:0]                     reg_read_valid_o,
    output logic [2*`REG_ADDR_WIDTH-1:0]   reg_read_addr_o,
    output logic                           use_imm_o,
    output logic [`DATA_WIDTH-1:0]         imm_o,
    output logic                           reg_write_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr_o,
    output decode_pkg::alu_op_e            aluop_o,
    output decode_pkg::alu_sel_e           alusel_o
);
    import decode_pkg::*;

    op_3r_e                     opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [`REG_ADDR_WIDTH-1:0] rk;

    assign opcode = op_3r_e'(instr_i[31:15]);
    assign rd     = instr_i[`RD_LSB +: `REG_ADDR_WIDTH];
    assign rj     = instr_i[`RJ_LSB +: `REG_ADDR_WIDTH];
    assign rk     = instr_i[`RK_LSB +: `REG_ADDR_WIDTH];

    // no immediate in this format
    assign use_imm_o = 1'b0;
    assign imm_o     = '0;

    always_comb begin
        match_o           = 1'b1;
        reg_read_valid_o  = 2'b11;
        reg_read_addr_o   = {rk, rj};
        reg_write_valid_o = 1'b1;
        reg_write_addr_o  = rd;
        aluop_o           = ALU_NOP;
        alusel_o          = SEL_ARITH;
        case (opcode)
            OP_ADD_W: aluop_o = ALU_ADD;
            OP_SUB_W: aluop_o = ALU_SUB;
            OP_SLT:   aluop_o = ALU_SLT;
            OP_SLTU:  aluop_o = ALU_SLTU;
            OP_AND: begin
                aluop_o  = ALU_AND;
                alusel_o = SEL_LOGIC;
            end
            OP_OR: begin
                aluop_o  = ALU_OR;
                alusel_o = SEL_LOGIC;
            end
            OP_XOR: begin
                aluop_o  = ALU_XOR;
                alusel_o = SEL_LOGIC;
            end
            default: begin
                match_o           = 1'b0;
                reg_read_valid_o  = '0;
                reg_read_addr_o   = '0;
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
                alusel_o          = SEL_NOP;
            end
        endcase
    end

endmodule

//--- src/decoder_1ri20.sv
`include "decode_defs.svh"

// 1RI20 format {opcode[7], si20, rd}
// lu12i.w and pcaddu12i
module decoder_1ri20 (
    input  logic [`DATA_WIDTH-1:0]         instr_i,
    output logic                           match_o,
    // {second, first}
    output logic [1:0]                     reg_read_valid_o,
    output logic [2*`REG_ADDR_WIDTH-1:0]   reg_read_addr_o,
    output logic                           use_imm_o,
    output logic [`DATA_WIDTH-1:0]         imm_o,
    output logic                           reg_write_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr_o,
    output decode_pkg::alu_op_e            aluop_o,
    output decode_pkg::alu_sel_e           alusel_o
);
    import decode_pkg::*;

    op_1ri20_e opcode;

    assign opcode = op_1ri20_e'(instr_i[31:25]);

    // never reads the register file
    assign reg_read_valid_o = '0;
    assign reg_read_addr_o  = '0;

    always_comb begin
        match_o  = 1'b1;
        aluop_o  = ALU_NOP;
        alusel_o = SEL_NOP;
        case (opcode)
            OP_LU12I_W: begin
                aluop_o  = ALU_LUI;
                alusel_o = SEL_MOVE;
            end
            OP_PCADDU12I: begin
                aluop_o  = ALU_PCADDU;
                alusel_o = SEL_ARITH;
            end
            default: match_o = 1'b0;
        endcase
        // upper immediate, low 12 bits cleared
        use_imm_o         = match_o;
        imm_o             = match_o ? {instr_i[24:5], 12'b0} : '0;
        reg_write_valid_o = match_o;
        reg_write_addr_o  = match_o ? instr_i[`RD_LSB +: `REG_ADDR_WIDTH] : '0;
    end

endmodule

//--- src/decode_stage.sv
`include "decode_defs.svh"

// decode stage: four format decoders in parallel, one id/ex register
module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           valid_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic [`DATA_WIDTH-1:0]         instr_i,
    input  logic [`DATA_WIDTH-1:0]         pc_i,
    output logic                           valid_o,
    output logic                           ine_o,
    output logic [`DATA_WIDTH-1:0]         pc_o,
    output logic [1:0]                     reg_read_valid_o,
    output logic [2*`REG_ADDR_WIDTH-1:0]   reg_read_addr_o,
    output logic                           use_imm_o,
    output logic [`DATA_WIDTH-1:0]         imm_o,
    output logic                           reg_write_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr_o,
    output decode_pkg::alu_op_e            aluop_o,
    output decode_pkg::alu_sel_e           alusel_o
);
    import decode_pkg::*;

    localparam int NUM_FMT = 4;

    // per-format results, index 0..3 = 2ri16, 2ri12, 3r, 1ri20
    logic [NUM_FMT-1:0]                          fmt_match;
    logic [NUM_FMT-1:0][1:0]                     fmt_read_valid;
    logic [NUM_FMT-1:0][2*`REG_ADDR_WIDTH-1:0]   fmt_read_addr;
    logic [NUM_FMT-1:0]                          fmt_use_imm;
    logic [NUM_FMT-1:0][`DATA_WIDTH-1:0]         fmt_imm;
    logic [NUM_FMT-1:0]                          fmt_write_valid;
    logic [NUM_FMT-1:0][`REG_ADDR_WIDTH-1:0]     fmt_write_addr;
    alu_op_e                                     fmt_aluop [NUM_FMT];
    alu_sel_e                                    fmt_alusel [NUM_FMT];

    // merged decode
    logic [1:0]                   dec_read_valid;
    logic [2*`REG_ADDR_WIDTH-1:0] dec_read_addr;
    logic                         dec_use_imm;
    logic [`DATA_WIDTH-1:0]       dec_imm;
    logic                         dec_write_valid;
    logic [`REG_ADDR_WIDTH-1:0]   dec_write_addr;
    alu_op_e                      dec_aluop;
    alu_sel_e                     dec_alusel;
    logic                         dec_ine;
    logic                         clear_stage;

    decoder_2ri16 u_dec_2ri16 (
        .instr_i(instr_i), .match_o(fmt_match[0]),
        .reg_read_valid_o(fmt_read_valid[0]), .reg_read_addr_o(fmt_read_addr[0]),
        .use_imm_o(fmt_use_imm[0]), .imm_o(fmt_imm[0]),
        .reg_write_valid_o(fmt_write_valid[0]), .reg_write_addr_o(fmt_write_addr[0]),
        .aluop_o(fmt_aluop[0]), .alusel_o(fmt_alusel[0])
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i(instr_i), .match_o(fmt_match[1]),
        .reg_read_valid_o(fmt_read_valid[1]), .reg_read_addr_o(fmt_read_addr[1]),
        .use_imm_o(fmt_use_imm[1]), .imm_o(fmt_imm[1]),
        .reg_write_valid_o(fmt_write_valid[1]), .reg_write_addr_o(fmt_write_addr[1]),
        .aluop_o(fmt_aluop[1]), .alusel_o(fmt_alusel[1])
    );

    decoder_3r u_dec_3r (
        .instr_i(instr_i), .match_o(fmt_match[2]),
        .reg_read_valid_o(fmt_read_valid[2]), .reg_read_addr_o(fmt_read_addr[2]),
        .use_imm_o(fmt_use_imm[2]), .imm_o(fmt_imm[2]),
        .reg_write_valid_o(fmt_write_valid[2]), .reg_write_addr_o(fmt_write_addr[2]),
        .aluop_o(fmt_aluop[2]), .alusel_o(fmt_alusel[2])
    );

    decoder_1ri20 u_dec_1ri20 (
        .instr_i(instr_i), .match_o(fmt_match[3]),
        .reg_read_valid_o(fmt_read_valid[3]), .reg_read_addr_o(fmt_read_addr[3]),
        .use_imm_o(fmt_use_imm[3]), .imm_o(fmt_imm[3]),
        .reg_write_valid_o(fmt_write_valid[3]), .reg_write_addr_o(fmt_write_addr[3]),
        .aluop_o(fmt_aluop[3]), .alusel_o(fmt_alusel[3])
    );

    // opcode spaces are disjoint, non-matching decoders output zero
    always_comb begin
        dec_read_valid  = '0;
        dec_read_addr   = '0;
        dec_use_imm     = 1'b0;
        dec_imm         = '0;
        dec_write_valid = 1'b0;
        dec_write_addr  = '0;
        dec_aluop       = ALU_NOP;
        dec_alusel      = SEL_NOP;
        for (int i = 0; i < NUM_FMT; i++) begin
            dec_read_valid  = dec_read_valid | fmt_read_valid[i];
            dec_read_addr   = dec_read_addr | fmt_read_addr[i];
            dec_use_imm     = dec_use_imm | fmt_use_imm[i];
            dec_imm         = dec_imm | fmt_imm[i];
            dec_write_valid = dec_write_valid | fmt_write_valid[i];
            dec_write_addr  = dec_write_addr | fmt_write_addr[i];
            dec_aluop       = alu_op_e'(dec_aluop | fmt_aluop[i]);
            dec_alusel      = alu_sel_e'(dec_alusel | fmt_alusel[i]);
        end
    end

    assign dec_ine = ~|fmt_match;

    // reset, flush (wins over stall) or a bubble when not stalled
    assign clear_stage = !rst_n_i || flush_i || (!stall_i && !valid_i);

    always_ff @(posedge clk) begin
        if (clear_stage) begin
            valid_o           <= 1'b0;
            ine_o             <= 1'b0;
            pc_o              <= '0;
            reg_read_valid_o  <= '0;
            reg_read_addr_o   <= '0;
            use_imm_o         <= 1'b0;
            imm_o             <= '0;
            reg_write_valid_o <= 1'b0;
            reg_write_addr_o  <= '0;
            aluop_o           <= ALU_NOP;
            alusel_o          <= SEL_NOP;
        end else if (!stall_i) begin
            valid_o           <= 1'b1;
            ine_o             <= dec_ine;
            pc_o              <= pc_i;
            reg_read_valid_o  <= dec_read_valid;
            reg_read_addr_o   <= dec_read_addr;
            use_imm_o         <= dec_use_imm;
            imm_o             <= dec_imm;
            reg_write_valid_o <= dec_write_valid;
            reg_write_addr_o  <= dec_write_addr;
            aluop_o           <= dec_aluop;
            alusel_o          <= dec_alusel;
        end
    end

endmodule

//--- verif/decode_stage_tb.sv
`include "decode_defs.svh"

module decode_stage_tb;
    import decode_pkg::*;

    localparam int TIMEOUT    = 20;
    localparam int NUM_PASSES = 4;

    // how the immediate field of the word becomes imm_o
    typedef enum logic [2:0] {
        IMM_NONE, IMM_SHIFT2, IMM_SEXT12, IMM_ZEXT12, IMM_UPPER20
    } imm_rule_e;

    // table row with opcode template and expected decode
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] tmpl;
        alu_op_e                op;
        alu_sel_e               sel;
        logic [1:0]             rv;
        logic                   wv;
        logic                   use_imm;
        imm_rule_e              rule;
        logic                   ine;
    } vector_t;

    // expected register contents in dut output order
    typedef struct packed {
        logic                         valid;
        logic                         ine;
        logic [`DATA_WIDTH-1:0]       pc;
        logic [1:0]                   rv;
        logic [2*`REG_ADDR_WIDTH-1:0] ra;
        logic                         use_imm;
        logic [`DATA_WIDTH-1:0]       imm;
        logic                         wv;
        logic [`REG_ADDR_WIDTH-1:0]   wa;
        alu_op_e                      op;
        alu_sel_e                     sel;
    } result_t;

    logic                         clk;
    logic                         rst_n_i;
    logic                         valid_i;
    logic                         stall_i;
    logic                         flush_i;
    logic [`DATA_WIDTH-1:0]       instr_i;
    logic [`DATA_WIDTH-1:0]       pc_i;
    logic                         valid_o;
    logic                         ine_o;
    logic [`DATA_WIDTH-1:0]       pc_o;
    logic [1:0]                   reg_read_valid_o;
    logic [2*`REG_ADDR_WIDTH-1:0] reg_read_addr_o;
    logic                         use_imm_o;
    logic [`DATA_WIDTH-1:0]       imm_o;
    logic                         reg_write_valid_o;
    logic [`REG_ADDR_WIDTH-1:0]   reg_write_addr_o;
    alu_op_e                      aluop_o;
    alu_sel_e                     alusel_o;

    result_t     exp_res;
    vector_t     vec_q[$];
    logic [31:0] lfsr;
    logic [31:0] word;

    decode_stage dut0 (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_bits(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
            report_fail($sformatf("error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
            report_fail($sformatf("error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e want);
        if (got !== want)
            report_fail($sformatf("error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic check_sel(input string name, input alu_sel_e got, input alu_sel_e want);
        if (got !== want)
            report_fail($sformatf("error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic check_outputs();
        check_flag("valid_o", valid_o, exp_res.valid);
        check_flag("ine_o", ine_o, exp_res.ine);
        check_bits("pc_o", pc_o, exp_res.pc);
        check_bits("reg_read_valid_o", reg_read_valid_o, exp_res.rv);
        check_bits("reg_read_addr_o", reg_read_addr_o, exp_res.ra);
        check_flag("use_imm_o", use_imm_o, exp_res.use_imm);
        check_bits("imm_o", imm_o, exp_res.imm);
        check_flag("reg_write_valid_o", reg_write_valid_o, exp_res.wv);
        check_bits("reg_write_addr_o", reg_write_addr_o, exp_res.wa);
        check_op("aluop_o", aluop_o, exp_res.op);
        check_sel("alusel_o", alusel_o, exp_res.sel);
    endtask

    task automatic add_vec(input logic [31:0] tmpl, input alu_op_e op, input alu_sel_e sel,
                           input logic [1:0] rv, input logic wv, input logic use_imm,
                           input imm_rule_e rule, input logic ine);
        vec_q.push_back({tmpl, op, sel, rv, wv, use_imm, rule, ine});
    endtask

    task automatic load_table();
        add_vec({OP_JIRL, 26'd0}, ALU_JIRL, SEL_JUMP, 2'b01, 1, 0, IMM_SHIFT2, 0);
        add_vec({OP_BEQ, 26'd0}, ALU_BEQ, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_BNE, 26'd0}, ALU_BNE, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_BLT, 26'd0}, ALU_BLT, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_BGE, 26'd0}, ALU_BGE, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_BLTU, 26'd0}, ALU_BLTU, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_BGEU, 26'd0}, ALU_BGEU, SEL_JUMP, 2'b11, 0, 0, IMM_SHIFT2, 0);
        add_vec({OP_SLTI, 22'd0}, ALU_SLT, SEL_ARITH, 2'b01, 1, 1, IMM_SEXT12, 0);
        add_vec({OP_SLTUI, 22'd0}, ALU_SLTU, SEL_ARITH, 2'b01, 1, 1, IMM_SEXT12, 0);
        add_vec({OP_ADDI_W, 22'd0}, ALU_ADD, SEL_ARITH, 2'b01, 1, 1, IMM_SEXT12, 0);
        add_vec({OP_ANDI, 22'd0}, ALU_AND, SEL_LOGIC, 2'b01, 1, 1, IMM_ZEXT12, 0);
        add_vec({OP_ORI, 22'd0}, ALU_OR, SEL_LOGIC, 2'b01, 1, 1, IMM_ZEXT12, 0);
        add_vec({OP_XORI, 22'd0}, ALU_XOR, SEL_LOGIC, 2'b01, 1, 1, IMM_ZEXT12, 0);
        add_vec({OP_LD_W, 22'd0}, ALU_LD_W, SEL_MEM, 2'b01, 1, 1, IMM_SEXT12, 0);
        add_vec({OP_ST_W, 22'd0}, ALU_ST_W, SEL_MEM, 2'b11, 0, 1, IMM_SEXT12, 0);
        add_vec({OP_ADD_W, 15'd0}, ALU_ADD, SEL_ARITH, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_SUB_W, 15'd0}, ALU_SUB, SEL_ARITH, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_SLT, 15'd0}, ALU_SLT, SEL_ARITH, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_SLTU, 15'd0}, ALU_SLTU, SEL_ARITH, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_AND, 15'd0}, ALU_AND, SEL_LOGIC, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_OR, 15'd0}, ALU_OR, SEL_LOGIC, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_XOR, 15'd0}, ALU_XOR, SEL_LOGIC, 2'b11, 1, 0, IMM_NONE, 0);
        add_vec({OP_LU12I_W, 25'd0}, ALU_LUI, SEL_MOVE, 2'b00, 1, 1, IMM_UPPER20, 0);
        add_vec({OP_PCADDU12I, 25'd0}, ALU_PCADDU, SEL_ARITH, 2'b00, 1, 1, IMM_UPPER20, 0);
        // no format owns major opcode 111111
        add_vec({6'b111111, 26'd0}, ALU_NOP, SEL_NOP, 2'b00, 0, 0, IMM_NONE, 1);
    endtask

    // draw the fields and build the word and its expected decode before driving it
    task automatic drive_vector(input vector_t v);
        logic [31:0] regs;
        logic [31:0] fld;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] imm;
        logic [9:0]  ra;
        logic [4:0]  second;
        draw_bits(15, regs);
        draw_bits(20, fld);
        draw_bits(32, pc);
        instr  = v.tmpl | regs[9:0];
        second = regs[4:0];
        imm    = '0;
        case (v.rule)
            IMM_SHIFT2: begin
                instr = instr | {fld[15:0], 10'b0};
                imm   = {{14{fld[15]}}, fld[15:0], 2'b00};
            end
            IMM_SEXT12, IMM_ZEXT12: begin
                instr = instr | {fld[11:0], 10'b0};
                imm   = {{20{fld[11] & (v.rule == IMM_SEXT12)}}, fld[11:0]};
            end
            IMM_UPPER20: begin
                instr = v.tmpl | {fld[19:0], regs[4:0]};
                imm   = {fld[19:0], 12'h000};
            end
            default: begin
                // second operand is rk in 3R
                instr  = v.tmpl | regs[14:0];
                second = regs[14:10];
            end
        endcase
        ra = {v.rv[1] ? second : 5'd0, v.rv[0] ? regs[9:5] : 5'd0};
        exp_res = {1'b1, v.ine, pc, v.rv, ra, v.use_imm, imm, v.wv,
                   v.wv ? regs[4:0] : 5'd0, v.op, v.sel};
        valid_i <= 1'b1;
        instr_i <= instr;
        pc_i    <= pc;
    endtask

    task automatic apply_vector(input vector_t v);
        int cycles;
        @(posedge clk);
        drive_vector(v);
        @(posedge clk);
        valid_i <= 1'b0;
        @(negedge clk);
        cycles = 1;
        while (!valid_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!valid_o)
            report_fail("timeout: valid_o never rose after an instruction was presented");
        if (cycles != 1)
            report_fail("decode result did not appear one cycle after the instruction");
        check_outputs();
    endtask

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        // a valid word during reset, so only the reset can clear the stage
        valid_i = 1'b1;
        stall_i = 1'b0;
        flush_i = 1'b0;
        instr_i = '0;
        pc_i    = '0;
        lfsr    = 32'h1798;
        load_table();
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        valid_i <= 1'b0;
        exp_res = '0;
        @(negedge clk);
        check_outputs();

        for (int p = 0; p < NUM_PASSES; p++) begin
            foreach (vec_q[i]) begin
                apply_vector(vec_q[i]);
            end
        end
        // valid_i low at the next edge leaves a bubble
        @(negedge clk);
        exp_res = '0;
        check_outputs();

        // stall holds the accepted decode while another word waits
        @(posedge clk);
        drive_vector(vec_q[0]);
        @(posedge clk);
        stall_i <= 1'b1;
        draw_bits(32, word);
        instr_i <= word;
        draw_bits(32, word);
        pc_i <= word;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_outputs();
        end

        // flush wins over the stall
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        stall_i <= 1'b0;
        valid_i <= 1'b0;
        exp_res = '0;
        @(negedge clk);
        check_outputs();

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+src
src/decode_pkg.sv
src/decoder_2ri16.sv
src/decoder_2ri12.sv
src/decoder_3r.sv
src/decoder_1ri20.sv
src/decode_stage.sv
verif/decode_stage_tb.sv
